// File: compile.f
verilog/conv_pkg.sv
verilog/coef_bank.sv
verilog/tap_multiplier.sv
verilog/tap_array.sv
verilog/sum_tree_round.sv
verilog/conv5x7.sv
verif/tb_clock_gen.sv
verif/conv_checker.sv
verif/tb_conv5x7.sv

// File: verif/conv_checker.sv
//********************
// Watches the convolution engine ports, predicts each result and
// compares it with pushout and res when it falls due
//********************

module conv_checker import conv_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cw,
	input  coef_addr_t ca,
	input  coef_t      cd,
	input  logic       push_samp,
	input  samp_t      samp [TAPS],
	input  logic       pushout,
	input  res_t       res,
	output int         value_errors,
	output int         protocol_errors,
	output int         checked,
	output int         pending
);
	timeunit 1ns;
	timeprecision 100ps;

	// Cycles from the push edge to the edge that sees pushout high
	localparam int LATENCY = 11;

	coef_t coef_model [TAPS];
	res_t exp_res [$];
	int exp_due [$];
	int exp_pushed [$];
	int cycle;

	// Full-precision sum of the window, then round and scale
	function automatic res_t window_result();
		acc_t total;
		acc_t cext;
		acc_t sext;
		total = '0;
		for (int i = 0; i < TAPS; i++) begin
			cext = coef_model[i];
			sext = samp[i];
			total = total + cext * sext;
		end
		if (total < 0) begin
			total = total + acc_t'(2 ** (FRAC_BITS - 1));
		end
		total = total >>> FRAC_BITS;
		return total[RES_W-1:0];
	endfunction

	initial begin
		value_errors = 0;
		protocol_errors = 0;
		checked = 0;
		pending = 0;
	end

	always @(posedge clk) begin
		if (reset) begin
			cycle = 0;
			exp_res.delete();
			exp_due.delete();
			exp_pushed.delete();
			for (int i = 0; i < TAPS; i++) begin
				coef_model[i] = '0;
			end
		end else begin
			cycle++;
			if (exp_due.size() > 0 && exp_due[0] == cycle) begin
				if (pushout !== 1'b1) begin
					$display("%0t: no pushout for the window pushed at cycle %0d",
						$time, exp_pushed[0]);
					protocol_errors++;
				end else begin
					checked++;
					if (res !== exp_res[0]) begin
						$display("[FAIL] %0t: res is %0d, expected %0d (window of cycle %0d)",
							$time, res, exp_res[0], exp_pushed[0]);
						value_errors++;
					end
				end
				exp_res.pop_front();
				exp_due.pop_front();
				exp_pushed.pop_front();
			end else if (pushout !== 1'b0) begin
				$display("%0t: pushout was high at cycle %0d with no window due",
					$time, cycle);
				protocol_errors++;
			end
			// A push sees the coefficients from before this edge's write
			if (push_samp) begin
				exp_res.push_back(window_result());
				exp_due.push_back(cycle + LATENCY);
				exp_pushed.push_back(cycle);
			end
			if (cw && ca < TAPS) begin
				coef_model[ca] = cd;
			end
		end
		pending = exp_due.size();
	end

endmodule

// File: verif/tb_clock_gen.sv
//********************
// Testbench clock, 10 ns period, reset held for three cycles
//********************

module tb_clock_gen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

// File: verif/tb_conv5x7.sv
//********************
// Testbench top for the convolution engine, applies the stimulus
// table one row per cycle and reports the checker's counts
//********************

module tb_conv5x7 import conv_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_ROWS = 256;
	localparam int C_VAL = 0;
	localparam int C_RAND = 1;
	localparam int S_ZERO = 0;
	localparam int S_MAX = 1;
	localparam int S_MIN = 2;
	localparam int S_RAND = 3;
	localparam int S_ONE = 4;
	localparam int S_FILL = 5;
	localparam longint HALF = 64'sd1 <<< (FRAC_BITS - 1);
	localparam longint STEP = 64'sd1 <<< FRAC_BITS;
	localparam longint COEF_MAX = (64'sd1 <<< (COEF_W - 1)) - 1;
	localparam longint COEF_MIN = -(64'sd1 <<< (COEF_W - 1));

	logic clk;
	logic reset;
	logic cw;
	coef_addr_t ca;
	coef_t cd;
	logic push_samp;
	samp_t samp [TAPS];
	logic pushout;
	res_t res;
	int value_errors;
	int protocol_errors;
	int checked;
	int pending;

	// Stimulus table, one entry per cycle
	bit row_wr [MAX_ROWS];
	int row_addr [MAX_ROWS];
	int row_cmode [MAX_ROWS];
	longint row_cval [MAX_ROWS];
	bit row_push [MAX_ROWS];
	int row_smode [MAX_ROWS];
	int row_sidx [MAX_ROWS];
	longint row_sval [MAX_ROWS];
	int n_rows;
	int n_pushes;
	bit table_built;
	integer seed;

	tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

	conv5x7 #(.N_TAPS(TAPS)) u_conv5x7 (
		.clk(clk), .reset(reset), .cw(cw), .ca(ca), .cd(cd),
		.push_samp(push_samp), .samp(samp), .pushout(pushout), .res(res)
	);

	conv_checker u_checker (
		.clk(clk), .reset(reset), .cw(cw), .ca(ca), .cd(cd),
		.push_samp(push_samp), .samp(samp), .pushout(pushout), .res(res),
		.value_errors(value_errors), .protocol_errors(protocol_errors),
		.checked(checked), .pending(pending)
	);

	task automatic add_row(input bit wr, input int addr, input int cmode, input longint cval,
		input bit push, input int smode, input int sidx, input longint sval);
		row_wr[n_rows] = wr;
		row_addr[n_rows] = addr;
		row_cmode[n_rows] = cmode;
		row_cval[n_rows] = cval;
		row_push[n_rows] = push;
		row_smode[n_rows] = smode;
		row_sidx[n_rows] = sidx;
		row_sval[n_rows] = sval;
		n_rows++;
		if (push) begin
			n_pushes++;
		end
	endtask

	task automatic add_write(input int addr, input int cmode, input longint cval);
		add_row(1'b1, addr, cmode, cval, 1'b0, S_ZERO, 0, 0);
	endtask

	task automatic add_push(input int smode, input int sidx, input longint sval);
		add_row(1'b0, 0, C_VAL, 0, 1'b1, smode, sidx, sval);
	endtask

	task automatic add_idle(input int cycles);
		repeat (cycles) add_row(1'b0, 0, C_VAL, 0, 1'b0, S_ZERO, 0, 0);
	endtask

	task automatic build_table();
		n_rows = 0;
		n_pushes = 0;
		add_idle(3);
		// All coefficients are still zero from reset
		add_push(S_RAND, 0, 0);
		add_push(S_MAX, 0, 0);
		add_idle(12);
		add_write(0, C_VAL, 1);
		add_push(S_ONE, 0, 3 * STEP + HALF);
		add_push(S_ONE, 0, -STEP + HALF - 1);
		add_push(S_ONE, 0, -STEP + HALF + 1);
		add_push(S_ONE, 0, -HALF);
		add_push(S_ONE, 0, -5 * STEP);
		add_push(S_ONE, 0, -7 * STEP - HALF - 1);
		add_write(17, C_VAL, -3);
		add_push(S_ONE, 17, 11184811);
		add_push(S_ONE, 17, -(1000 * STEP + 7));
		add_idle(12);
		for (int i = 0; i < TAPS; i++) begin
			add_write(i, C_RAND, 0);
		end
		repeat (4) add_push(S_RAND, 0, 0);
		add_row(1'b1, 9, C_RAND, 0, 1'b1, S_RAND, 0, 0);
		add_push(S_RAND, 0, 0);
		add_idle(12);
		// Write in the push cycle, then writes past the last tap
		add_row(1'b1, 5, C_VAL, 7, 1'b1, S_FILL, 0, 1000);
		add_push(S_FILL, 0, 1000);
		add_write(35, C_VAL, 99);
		add_write(40, C_VAL, -1);
		add_write(63, C_VAL, COEF_MAX);
		add_push(S_FILL, 0, 1000);
		add_push(S_RAND, 0, 0);
		add_idle(12);
		for (int i = 0; i < TAPS; i++) begin
			add_write(i, C_VAL, COEF_MAX);
		end
		add_push(S_MAX, 0, 0);
		add_push(S_MIN, 0, 0);
		for (int i = 0; i < TAPS; i++) begin
			add_write(i, C_VAL, COEF_MIN);
		end
		add_push(S_MAX, 0, 0);
		add_push(S_MIN, 0, 0);
		add_idle(12);
	endtask

	task automatic apply_row(input int r);
		cw = row_wr[r];
		ca = coef_addr_t'(row_addr[r]);
		if (row_cmode[r] == C_RAND) begin
			cd = coef_t'({$random(seed), $random(seed)});
		end else begin
			cd = coef_t'(row_cval[r]);
		end
		push_samp = row_push[r];
		for (int i = 0; i < TAPS; i++) begin
			case (row_smode[r])
				S_MAX: samp[i] = {1'b0, {(SAMP_W-1){1'b1}}};
				S_MIN: samp[i] = {1'b1, {(SAMP_W-1){1'b0}}};
				S_RAND: samp[i] = samp_t'({$random(seed), $random(seed)});
				S_ONE: samp[i] = (i == row_sidx[r]) ? samp_t'(row_sval[r]) : '0;
				S_FILL: samp[i] = samp_t'(row_sval[r]);
				default: samp[i] = '0;
			endcase
		end
	endtask

	// Ends a run that never drains its pipeline
	initial begin
		longint limit_ns;
		wait (table_built);
		limit_ns = (n_rows + 11 + 20) * 10;
		#(limit_ns);
		$display("Watchdog timeout: the run did not finish within %0d ns", limit_ns);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int total_errors;
		seed = 32'h3da8_89fb;
		cw = 1'b0;
		ca = '0;
		cd = '0;
		push_samp = 1'b0;
		for (int i = 0; i < TAPS; i++) begin
			samp[i] = '0;
		end
		table_built = 1'b0;
		build_table();
		table_built = 1'b1;
		wait (reset === 1'b0);
		for (int r = 0; r < n_rows; r++) begin
			apply_row(r);
			@(posedge clk);
			#1;
		end
		cw = 1'b0;
		push_samp = 1'b0;
		repeat (2) @(posedge clk);
		wait (pending == 0);
		repeat (2) @(posedge clk);
		total_errors = value_errors + protocol_errors;
		if (checked != n_pushes) begin
			$display("Only %0d of %0d pushed windows produced a checked result",
				checked, n_pushes);
			total_errors++;
		end
		$display("Errors: %0d value, %0d protocol, %0d of %0d results checked",
			value_errors, protocol_errors, checked, n_pushes);
		if (total_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/coef_bank.sv
//********************
// Coefficient register file, loaded one word at a time by the host
//********************

module coef_bank import conv_pkg::*; #(
	parameter int N_TAPS = TAPS
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       cw,
	input  coef_addr_t ca,
	input  coef_t      cd,
	output coef_t      coefs [N_TAPS]
);

	// Each tap register decodes its own address, so writes past the
	// last tap match nothing and are dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_TAPS; i++) begin
				coefs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < N_TAPS; i++) begin
				if (cw && ca == coef_addr_t'(i)) begin
					coefs[i] <= cd;
				end
			end
		end
	end

	// A write with unknown data would poison every later window
	// that uses this tap
	a_cd_known: assert property (
		@(posedge clk) disable iff (reset)
		cw |-> !$isunknown(cd)
	) else $error("coefficient write with unknown data at address %0d", ca);

endmodule

// File: verilog/conv5x7.sv
//********************
// 5x7 convolution engine top, host coefficient port in, one
// rounded result per sample window out
//********************

module conv5x7 import conv_pkg::*; #(
	parameter int N_TAPS = TAPS
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       cw,
	input  coef_addr_t ca,
	input  coef_t      cd,
	input  logic       push_samp,
	input  samp_t      samp [N_TAPS],
	output logic       pushout,
	output res_t       res
);

	coef_t coefs [N_TAPS];
	prod_t prods [N_TAPS];
	logic prod_valid;

	coef_bank #(.N_TAPS(N_TAPS)) u_coef_bank (
		.clk   (clk),
		.reset (reset),
		.cw    (cw),
		.ca    (ca),
		.cd    (cd),
		.coefs (coefs)
	);

	tap_array #(.N_TAPS(N_TAPS)) u_tap_array (
		.clk        (clk),
		.reset      (reset),
		.push_samp  (push_samp),
		.samp       (samp),
		.coefs      (coefs),
		.prods      (prods),
		.prod_valid (prod_valid)
	);

	sum_tree_round #(.N_TAPS(N_TAPS)) u_sum_tree_round (
		.clk        (clk),
		.reset      (reset),
		.prods      (prods),
		.prod_valid (prod_valid),
		.pushout    (pushout),
		.res        (res)
	);

endmodule

// File: verilog/conv_pkg.sv
//********************
// Widths, types and tap geometry shared by every block of the
// convolution engine. Import with conv_pkg::* in the module header
//********************

package conv_pkg;

	// Window geometry, one word per position
	localparam int ROWS = 7;
	localparam int COLS = 5;
	localparam int TAPS = ROWS * COLS;

	localparam int SAMP_W = 40;
	localparam int COEF_W = 33;
	localparam int PROD_W = SAMP_W + COEF_W;
	localparam int ACC_W = 80;
	localparam int RES_W = 45;
	localparam int FRAC_BITS = 25;
	localparam int ADDR_W = 6;

	// Two multiply stages plus the product register
	localparam int MULT_STAGES = 3;

	typedef logic signed [SAMP_W-1:0] samp_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic signed [RES_W-1:0] res_t;
	typedef logic [ADDR_W-1:0] coef_addr_t;

	// Number of pairwise adder levels that bring n terms down to one
	function automatic int tree_depth(int n);
		int depth;
		int cnt;
		depth = 0;
		cnt = n;
		while (cnt > 1) begin
			cnt = (cnt + 1) / 2;
			depth++;
		end
		return depth;
	endfunction

endpackage

// File: verilog/sum_tree_round.sv
//********************
// Registered pairwise adder tree over all tap products, then
// rounding toward zero and scaling down to the result width
//********************

module sum_tree_round import conv_pkg::*; #(
	parameter int N_TAPS = TAPS
) (
	input  logic  clk,
	input  logic  reset,
	input  prod_t prods [N_TAPS],
	input  logic  prod_valid,
	output logic  pushout,
	output res_t  res
);

	localparam int DEPTH = tree_depth(N_TAPS);

	// Terms left after k pairwise levels
	function automatic int level_count(int n, int k);
		int cnt;
		cnt = n;
		for (int i = 0; i < k; i++) begin
			cnt = (cnt + 1) / 2;
		end
		return cnt;
	endfunction

	acc_t lvl [1:DEPTH][N_TAPS];
	logic [DEPTH-1:0] vld_sr;
	acc_t biased;
	acc_t scaled;

	for (genvar k = 1; k <= DEPTH; k++) begin : g_lvl
		localparam int N_IN = level_count(N_TAPS, k - 1);
		localparam int N_OUT = level_count(N_TAPS, k);

		for (genvar j = 0; j < N_OUT; j++) begin : g_node
			acc_t left;
			acc_t right;

			// First level sign-extends straight from the products
			if (k == 1) begin : g_leaf
				assign left = prods[2*j];
				if (2*j + 1 < N_IN) begin : g_pair
					assign right = prods[2*j+1];
				end else begin : g_odd
					assign right = '0;
				end
			end else begin : g_inner
				assign left = lvl[k-1][2*j];
				if (2*j + 1 < N_IN) begin : g_pair
					assign right = lvl[k-1][2*j+1];
				end else begin : g_odd
					assign right = '0;
				end
			end

			always_ff @(posedge clk) begin
				if (reset) begin
					lvl[k][j] <= '0;
				end else begin
					lvl[k][j] <= left + right;
				end
			end
		end
	end

	// Negative sums get half an LSB less than a full step before the
	// shift, so the result rounds toward zero on ties
	always_comb begin
		biased = lvl[DEPTH][0];
		if (lvl[DEPTH][0][ACC_W-1]) begin
			biased = lvl[DEPTH][0] + (acc_t'(1) <<< (FRAC_BITS - 1));
		end
		scaled = biased >>> FRAC_BITS;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			vld_sr <= '0;
			pushout <= 1'b0;
			res <= '0;
		end else begin
			vld_sr <= (vld_sr << 1) | DEPTH'(prod_valid);
			pushout <= vld_sr[DEPTH-1];
			res <= scaled[RES_W-1:0];
		end
	end

	a_push_follows: assert property (
		@(posedge clk) disable iff (reset)
		prod_valid |-> ##(DEPTH + 1) pushout
	) else $error("pushout missing %0d cycles after prod_valid", DEPTH + 1);

	a_push_source: assert property (
		@(posedge clk) disable iff (reset)
		pushout |-> $past(prod_valid, DEPTH + 1)
	) else $error("pushout without a matching prod_valid");

endmodule

// File: verilog/tap_array.sv
//********************
// Captures a sample window with its coefficients and multiplies
// every tap in parallel, valid bit follows the products
//********************

module tap_array import conv_pkg::*; #(
	parameter int N_TAPS = TAPS
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  push_samp,
	input  samp_t samp [N_TAPS],
	input  coef_t coefs [N_TAPS],
	output prod_t prods [N_TAPS],
	output logic  prod_valid
);

	samp_t samp_q [N_TAPS];
	coef_t coef_q [N_TAPS];

	// One bit for the capture register plus one per multiplier stage
	logic [MULT_STAGES:0] push_sr;

	// Coefficients are snapshotted with the window, so a write in the
	// push cycle only reaches the next window
	always_ff @(posedge clk) begin
		if (reset) begin
			push_sr <= '0;
			for (int i = 0; i < N_TAPS; i++) begin
				samp_q[i] <= '0;
				coef_q[i] <= '0;
			end
		end else begin
			push_sr <= {push_sr[MULT_STAGES-1:0], push_samp};
			if (push_samp) begin
				samp_q <= samp;
				coef_q <= coefs;
			end
		end
	end

	assign prod_valid = push_sr[MULT_STAGES];

	for (genvar i = 0; i < N_TAPS; i++) begin : g_tap
		tap_multiplier u_mult (
			.clk   (clk),
			.reset (reset),
			.a     (coef_q[i]),
			.b     (samp_q[i]),
			.p     (prods[i])
		);
	end

	a_push_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(push_samp)
	) else $error("push_samp is unknown");

endmodule

// File: verilog/tap_multiplier.sv
//********************
// Signed coefficient by sample multiplier for one tap, three
// register stages from operands to product
//********************

module tap_multiplier import conv_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  coef_t a,
	input  samp_t b,
	output prod_t p
);

	localparam int LO_W = SAMP_W / 2;
	localparam int HI_W = SAMP_W - LO_W;

	// The upper half of the sample carries its sign, the lower half
	// is treated as an unsigned magnitude
	logic signed [COEF_W+HI_W-1:0] pp_hi;
	logic signed [COEF_W+LO_W:0] pp_lo;
	prod_t sum_q;

	// Stage 1 forms the two partial products
	always_ff @(posedge clk) begin
		if (reset) begin
			pp_hi <= '0;
			pp_lo <= '0;
		end else begin
			pp_hi <= a * $signed(b[SAMP_W-1:LO_W]);
			pp_lo <= a * $signed({1'b0, b[LO_W-1:0]});
		end
	end

	// Stage 2 aligns the upper partial product and adds
	always_ff @(posedge clk) begin
		if (reset) begin
			sum_q <= '0;
		end else begin
			sum_q <= (prod_t'(pp_hi) <<< LO_W) + prod_t'(pp_lo);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			p <= '0;
		end else begin
			p <= sum_q;
		end
	end

endmodule
